// ==== design/cache_pkg.sv ====
package cache_pkg;

   localparam int addr_w      = 32;
   localparam int lg_cl_len   = 4;                       // 16 byte lines
   localparam int line_w      = 1 << (lg_cl_len + 3);
   localparam int lg_l2_lines = 4;
   localparam int l2_lines    = 1 << lg_l2_lines;
   localparam int tag_w       = addr_w - lg_l2_lines - lg_cl_len;

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [line_w-1:0] line_t;

   typedef enum logic {
      mem_ld_line = 1'b0,
      mem_st_line = 1'b1
   } mem_op_t;

   // line request from either L1
   typedef struct packed {
      addr_t   addr;
      mem_op_t op;
      line_t   data;
   } l1_req_t;

   typedef struct packed {
      addr_t   addr;
      mem_op_t opcode;
      line_t   store_data;
   } mem_req_t;

   typedef enum logic {
      src_l1i = 1'b0,
      src_l1d = 1'b1
   } l1_src_t;

   typedef enum logic [2:0] {
      flush_idle       = 3'd0,
      wait_for_l1d_l1i = 3'd1,
      got_l1d          = 3'd2,
      got_l1i          = 3'd3,
      flush_l2         = 3'd4
   } flush_state_t;

endpackage

// ==== design/flush_sequencer.sv ====
`timescale 1ns/1ps

module flush_sequencer
   import cache_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_done,
   output logic l2_flush_start,
   output logic in_flush_mode
);

   flush_state_t state, n_state;
   logic r_flush, n_flush;
   logic r_start, n_start;

   assign in_flush_mode  = r_flush;
   assign l2_flush_start = r_start;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= flush_idle;
         r_flush <= 1'b0;
         r_start <= 1'b0;
      end
      else
      begin
         state   <= n_state;
         r_flush <= n_flush;
         r_start <= n_start;
      end
   end

   always_comb
   begin
      n_state = state;
      n_flush = r_flush;
      n_start = 1'b0;
      case (state)
         flush_idle:
         begin
            // a side that is not asked to flush counts as done
            if (flush_req_l1i && flush_req_l1d)
               n_state = wait_for_l1d_l1i;
            else if (flush_req_l1i)
               n_state = got_l1d;
            else if (flush_req_l1d)
               n_state = got_l1i;
            if (flush_req_l1i || flush_req_l1d)
               n_flush = 1'b1;
         end
         wait_for_l1d_l1i:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state = flush_l2;
               n_start = 1'b1;
            end
            else if (l1d_flush_complete)
               n_state = got_l1d;
            else if (l1i_flush_complete)
               n_state = got_l1i;
         end
         got_l1d:
         begin
            if (l1i_flush_complete)
            begin
               n_state = flush_l2;
               n_start = 1'b1;
            end
         end
         got_l1i:
         begin
            if (l1d_flush_complete)
            begin
               n_state = flush_l2;
               n_start = 1'b1;
            end
         end
         flush_l2:
         begin
            if (l2_flush_done)
            begin
               n_state = flush_idle;
               n_flush = 1'b0;
            end
         end
         default:
            n_state = flush_idle;
      endcase
   end

   // the L2 only finishes a walk that this FSM started
   a_done_in_flush_l2: assert property (
      @(posedge clk) disable iff (reset)
      l2_flush_done |-> (state == flush_l2)
   );

endmodule

// ==== design/l1_req_arbiter.sv ====
`timescale 1ns/1ps

module l1_req_arbiter
   import cache_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    l1d_req_valid,
   input  l1_req_t l1d_req,
   input  logic    l1i_req_valid,
   input  addr_t   l1i_req_addr,
   output logic    l1d_req_ack,
   output logic    l1i_req_ack,
   output logic    l1d_rsp_valid,
   output logic    l1i_rsp_valid,
   output logic    arb_valid,
   output l1_req_t arb_req,
   output l1_src_t arb_src,
   input  logic    arb_ack,
   input  logic    rsp_valid
);

   logic    r_busy;
   l1_src_t r_owner;
   l1_req_t l1i_req;

   // icache only ever loads
   assign l1i_req = '{addr: l1i_req_addr, op: mem_ld_line, data: '0};

   assign arb_valid = (l1d_req_valid || l1i_req_valid) && !r_busy;
   assign arb_src   = l1d_req_valid ? src_l1d : src_l1i;   // dcache first
   assign arb_req   = l1d_req_valid ? l1d_req : l1i_req;

   assign l1d_req_ack = arb_ack && (arb_src == src_l1d);
   assign l1i_req_ack = arb_ack && (arb_src == src_l1i);

   assign l1d_rsp_valid = rsp_valid && (r_owner == src_l1d);
   assign l1i_rsp_valid = rsp_valid && (r_owner == src_l1i);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_busy  <= 1'b0;
         r_owner <= src_l1i;
      end
      else if (arb_ack)
      begin
         r_busy  <= 1'b1;
         r_owner <= arb_src;
      end
      else if (rsp_valid)
         r_busy <= 1'b0;
   end

   a_rsp_has_owner: assert property (
      @(posedge clk) disable iff (reset)
      rsp_valid |-> r_busy
   );

endmodule

// ==== design/l2_arrays.sv ====
`timescale 1ns/1ps

module l2_arrays
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic [lg_l2_lines-1:0] rd_index,
   output logic [tag_w-1:0]       rd_tag,
   output logic                   rd_valid,
   output logic                   rd_dirty,
   output line_t                  rd_line,
   input  logic                   wr_en,
   input  logic [lg_l2_lines-1:0] wr_index,
   input  logic [tag_w-1:0]       wr_tag,
   input  logic                   wr_dirty,
   input  line_t                  wr_line,
   input  logic                   inval_all
);

   logic [tag_w-1:0]    tag_mem [l2_lines];
   line_t               data_mem [l2_lines];
   logic [l2_lines-1:0] valid_bits;
   logic [l2_lines-1:0] dirty_bits;

   // state bits, cleared as a whole
   always_ff @(posedge clk)
   begin
      if (reset || inval_all)
      begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end
      else if (wr_en)
      begin
         valid_bits[wr_index] <= 1'b1;
         dirty_bits[wr_index] <= wr_dirty;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         tag_mem[wr_index]  <= wr_tag;
         data_mem[wr_index] <= wr_line;
      end
   end

   // registered read, old contents on a same cycle write
   always_ff @(posedge clk)
   begin
      rd_tag   <= tag_mem[rd_index];
      rd_line  <= data_mem[rd_index];
      rd_valid <= valid_bits[rd_index];
      rd_dirty <= dirty_bits[rd_index];
   end

endmodule

// ==== design/l2_ctrl.sv ====
`timescale 1ns/1ps

module l2_ctrl
   import cache_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   arb_valid,
   input  l1_req_t                arb_req,
   input  l1_src_t                arb_src,
   output logic                   arb_ack,
   output logic                   rsp_valid,
   output line_t                  l1_load_data,
   input  logic                   l2_flush_start,
   output logic                   l2_flush_done,
   output logic [lg_l2_lines-1:0] rd_index,
   input  logic [tag_w-1:0]       rd_tag,
   input  logic                   rd_valid,
   input  logic                   rd_dirty,
   input  line_t                  rd_line,
   output logic                   wr_en,
   output logic [lg_l2_lines-1:0] wr_index,
   output logic [tag_w-1:0]       wr_tag,
   output logic                   wr_dirty,
   output line_t                  wr_line,
   output logic                   inval_all,
   output logic                   mem_req_valid,
   output mem_req_t               mem_req,
   input  logic                   mem_rsp_valid,
   input  line_t                  mem_rsp_load_data,
   output logic [63:0]            l2_cache_accesses,
   output logic [63:0]            l2_cache_hits
);

   typedef enum logic [3:0] {
      st_idle,
      st_lookup,
      st_wb,
      st_fill,
      st_resp,
      st_flush_rd,
      st_flush_chk,
      st_flush_wb,
      st_flush_inval
   } ctrl_state_t;

   ctrl_state_t            state;
   l1_req_t                r_req;
   line_t                  r_line;
   mem_req_t               r_mem_req;
   logic                   r_mem_valid;
   logic                   r_flush_pend;
   logic [lg_l2_lines-1:0] r_flush_idx;

   logic [lg_l2_lines-1:0] req_idx;
   logic [tag_w-1:0]       req_tag;
   logic                   is_store;
   logic                   hit;
   logic                   victim_dirty;
   logic                   flush_go;
   logic                   walk_next;

   assign req_idx      = r_req.addr[lg_cl_len +: lg_l2_lines];
   assign req_tag      = r_req.addr[addr_w-1 -: tag_w];
   assign is_store     = (r_req.op == mem_st_line);
   assign hit          = rd_valid && (rd_tag == req_tag);
   assign victim_dirty = rd_valid && rd_dirty && (rd_tag != req_tag);
   assign flush_go     = l2_flush_start || r_flush_pend;

   // next index once this line is clean or written back
   assign walk_next = ((state == st_flush_chk) && !(rd_valid && rd_dirty)) ||
                      ((state == st_flush_wb) && mem_rsp_valid);

   assign arb_ack       = (state == st_idle) && !flush_go && arb_valid;
   assign rsp_valid     = (state == st_resp);
   assign l1_load_data  = r_line;
   assign l2_flush_done = (state == st_flush_inval);
   assign inval_all     = (state == st_flush_inval);
   assign mem_req_valid = r_mem_valid;
   assign mem_req       = r_mem_req;

   always_comb
   begin
      if (state == st_idle)
         rd_index = arb_req.addr[lg_cl_len +: lg_l2_lines];   // lookup starts at ack
      else if (state == st_flush_rd)
         rd_index = r_flush_idx;
      else
         rd_index = req_idx;
   end

   always_comb
   begin
      wr_en    = 1'b0;
      wr_index = req_idx;
      wr_tag   = req_tag;
      wr_dirty = is_store;
      wr_line  = r_req.data;
      case (state)
         st_lookup:
            wr_en = is_store && !victim_dirty;
         st_wb:
            wr_en = is_store && mem_rsp_valid;
         st_fill:
         begin
            wr_en   = r_mem_valid && mem_rsp_valid;
            wr_line = mem_rsp_load_data;
         end
         default:
            wr_en = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state             <= st_idle;
         r_mem_valid       <= 1'b0;
         r_flush_pend      <= 1'b0;
         r_flush_idx       <= '0;
         l2_cache_accesses <= '0;
         l2_cache_hits     <= '0;
      end
      else
      begin
         if (l2_flush_start && (state != st_idle))
            r_flush_pend <= 1'b1;   // held until idle
         case (state)
            st_idle:
            begin
               if (flush_go)
               begin
                  r_flush_pend <= 1'b0;
                  r_flush_idx  <= '0;
                  state        <= st_flush_rd;
               end
               else if (arb_valid)
               begin
                  r_req             <= arb_req;
                  l2_cache_accesses <= l2_cache_accesses + 64'd1;
                  state             <= st_lookup;
               end
            end
            st_lookup:
            begin
               if (hit)
                  l2_cache_hits <= l2_cache_hits + 64'd1;
               r_line <= rd_line;
               if (victim_dirty)
               begin
                  r_mem_req   <= '{addr: {rd_tag, req_idx, {lg_cl_len{1'b0}}},
                                   opcode: mem_st_line, store_data: rd_line};
                  r_mem_valid <= 1'b1;
                  state       <= st_wb;
               end
               else if (is_store || hit)
                  state <= st_resp;
               else
                  state <= st_fill;
            end
            st_wb:
            begin
               if (mem_rsp_valid)
               begin
                  r_mem_valid <= 1'b0;
                  state       <= is_store ? st_resp : st_fill;
               end
            end
            st_fill:
            begin
               if (!r_mem_valid)
               begin
                  r_mem_req   <= '{addr: {req_tag, req_idx, {lg_cl_len{1'b0}}},
                                   opcode: mem_ld_line, store_data: '0};
                  r_mem_valid <= 1'b1;
               end
               else if (mem_rsp_valid)
               begin
                  r_mem_valid <= 1'b0;
                  r_line      <= mem_rsp_load_data;
                  state       <= st_resp;
               end
            end
            st_resp:
               state <= st_idle;
            st_flush_rd:
               state <= st_flush_chk;
            st_flush_chk:
            begin
               if (rd_valid && rd_dirty)
               begin
                  r_mem_req   <= '{addr: {rd_tag, r_flush_idx, {lg_cl_len{1'b0}}},
                                   opcode: mem_st_line, store_data: rd_line};
                  r_mem_valid <= 1'b1;
                  state       <= st_flush_wb;
               end
            end
            st_flush_wb:
            begin
               if (mem_rsp_valid)
                  r_mem_valid <= 1'b0;
            end
            st_flush_inval:
               state <= st_idle;
            default:
               state <= st_idle;
         endcase
         if (walk_next)
         begin
            if (&r_flush_idx)
               state <= st_flush_inval;
            else
            begin
               r_flush_idx <= r_flush_idx + 1'b1;
               state       <= st_flush_rd;
            end
         end
      end
   end

   a_mem_req_stable: assert property (
      @(posedge clk) disable iff (reset)
      mem_req_valid && !mem_rsp_valid |=> mem_req_valid && $stable(mem_req)
   );

   // only the dcache side can present a store
   a_store_from_l1d: assert property (
      @(posedge clk) disable iff (reset)
      arb_valid && (arb_req.op == mem_st_line) |-> (arb_src == src_l1d)
   );

endmodule

// ==== design/l1_l2_fabric.sv ====
`timescale 1ns/1ps

module l1_l2_fabric
   import cache_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        l1d_req_valid,
   input  l1_req_t     l1d_req,
   output logic        l1d_req_ack,
   output logic        l1d_rsp_valid,
   input  logic        l1i_req_valid,
   input  addr_t       l1i_req_addr,
   output logic        l1i_req_ack,
   output logic        l1i_rsp_valid,
   output line_t       l1_load_data,
   input  logic        flush_req_l1i,
   input  logic        flush_req_l1d,
   input  logic        l1i_flush_complete,
   input  logic        l1d_flush_complete,
   output logic        in_flush_mode,
   output logic        mem_req_valid,
   output mem_req_t    mem_req,
   input  logic        mem_rsp_valid,
   input  line_t       mem_rsp_load_data,
   output logic [63:0] l2_cache_accesses,
   output logic [63:0] l2_cache_hits
);

   logic                   arb_valid;
   l1_req_t                arb_req;
   l1_src_t                arb_src;
   logic                   arb_ack;
   logic                   rsp_valid;
   logic                   l2_flush_start;
   logic                   l2_flush_done;

   logic [lg_l2_lines-1:0] rd_index;
   logic [tag_w-1:0]       rd_tag;
   logic                   rd_valid;
   logic                   rd_dirty;
   line_t                  rd_line;
   logic                   wr_en;
   logic [lg_l2_lines-1:0] wr_index;
   logic [tag_w-1:0]       wr_tag;
   logic                   wr_dirty;
   line_t                  wr_line;
   logic                   inval_all;

   flush_sequencer u_flush_seq (
      .clk                (clk),
      .reset              (reset),
      .flush_req_l1i      (flush_req_l1i),
      .flush_req_l1d      (flush_req_l1d),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .l2_flush_done      (l2_flush_done),
      .l2_flush_start     (l2_flush_start),
      .in_flush_mode      (in_flush_mode)
   );

   l1_req_arbiter u_arb (
      .clk           (clk),
      .reset         (reset),
      .l1d_req_valid (l1d_req_valid),
      .l1d_req       (l1d_req),
      .l1i_req_valid (l1i_req_valid),
      .l1i_req_addr  (l1i_req_addr),
      .l1d_req_ack   (l1d_req_ack),
      .l1i_req_ack   (l1i_req_ack),
      .l1d_rsp_valid (l1d_rsp_valid),
      .l1i_rsp_valid (l1i_rsp_valid),
      .arb_valid     (arb_valid),
      .arb_req       (arb_req),
      .arb_src       (arb_src),
      .arb_ack       (arb_ack),
      .rsp_valid     (rsp_valid)
   );

   l2_ctrl u_l2_ctrl (
      .clk               (clk),
      .reset             (reset),
      .arb_valid         (arb_valid),
      .arb_req           (arb_req),
      .arb_src           (arb_src),
      .arb_ack           (arb_ack),
      .rsp_valid         (rsp_valid),
      .l1_load_data      (l1_load_data),
      .l2_flush_start    (l2_flush_start),
      .l2_flush_done     (l2_flush_done),
      .rd_index          (rd_index),
      .rd_tag            (rd_tag),
      .rd_valid          (rd_valid),
      .rd_dirty          (rd_dirty),
      .rd_line           (rd_line),
      .wr_en             (wr_en),
      .wr_index          (wr_index),
      .wr_tag            (wr_tag),
      .wr_dirty          (wr_dirty),
      .wr_line           (wr_line),
      .inval_all         (inval_all),
      .mem_req_valid     (mem_req_valid),
      .mem_req           (mem_req),
      .mem_rsp_valid     (mem_rsp_valid),
      .mem_rsp_load_data (mem_rsp_load_data),
      .l2_cache_accesses (l2_cache_accesses),
      .l2_cache_hits     (l2_cache_hits)
   );

   l2_arrays u_l2_arrays (
      .clk       (clk),
      .reset     (reset),
      .rd_index  (rd_index),
      .rd_tag    (rd_tag),
      .rd_valid  (rd_valid),
      .rd_dirty  (rd_dirty),
      .rd_line   (rd_line),
      .wr_en     (wr_en),
      .wr_index  (wr_index),
      .wr_tag    (wr_tag),
      .wr_dirty  (wr_dirty),
      .wr_line   (wr_line),
      .inval_all (inval_all)
   );

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model
   import cache_pkg::*;
#(
   parameter integer seed_init = 1
)
(
   input  logic     clk,
   input  logic     reset,
   input  logic     mem_req_valid,
   input  mem_req_t mem_req,
   output logic     mem_rsp_valid,
   output line_t    mem_rsp_load_data
);

   line_t       lines [addr_t];        // only lines written so far
   logic [31:0] n_req   = '0;
   integer      seed    = seed_init;
   logic        busy    = 1'b0;
   logic [3:0]  delay   = '0;
   mem_req_t    cur;
   logic        r_valid = 1'b0;
   line_t       r_data  = '0;

   assign mem_rsp_valid     = r_valid;
   assign mem_rsp_load_data = r_data;

   // unwritten lines hold their own line address in every word
   function automatic line_t fill_line(input addr_t a);
      return {4{a[addr_w-1:lg_cl_len], {lg_cl_len{1'b0}}}};
   endfunction

   always @(posedge clk)
   begin
      if (reset)
      begin
         busy    <= 1'b0;
         r_valid <= 1'b0;
      end
      else
      begin
         r_valid <= 1'b0;
         if (busy)
         begin
            if (delay == 4'd1)
            begin
               busy    <= 1'b0;
               r_valid <= 1'b1;
               if (cur.opcode == mem_st_line)
                  lines[cur.addr] = cur.store_data;
               else
                  r_data <= lines.exists(cur.addr) ? lines[cur.addr] : fill_line(cur.addr);
            end
            else
               delay <= delay - 4'd1;
         end
         else if (mem_req_valid && !r_valid)   // request drops after the pulse
         begin
            busy  <= 1'b1;
            cur   <= mem_req;
            delay <= 4'(($unsigned($random(seed)) % 8) + 1);
            n_req <= n_req + 32'd1;
         end
      end
   end

endmodule

// ==== test/tb_l1_l2_fabric.sv ====
`timescale 1ns/1ps

module tb_l1_l2_fabric
   import cache_pkg::*;
;

   localparam integer seed_value  = 32'h6465_dd83;
   localparam int     cycle_limit = 4000;
   localparam addr_t  addr_a      = 32'h0000_1230;
   localparam addr_t  addr_b      = 32'h0000_5630;   // same index as addr_a
   localparam addr_t  addr_c      = 32'h0000_2340;

   typedef struct packed {
      line_t       data;
      logic        load;
      logic        hit;
      logic [7:0]  mem_ops;
      logic [31:0] mem_base;
      logic [31:0] ack_cycle;
      l1_src_t     src;
   } exp_t;

   logic clk;
   logic reset;
   logic l1d_req_valid, l1d_req_ack, l1d_rsp_valid;
   logic l1i_req_valid, l1i_req_ack, l1i_rsp_valid;
   logic flush_req_l1i, flush_req_l1d, l1i_flush_complete, l1d_flush_complete;
   logic in_flush_mode, mem_req_valid, mem_rsp_valid;
   l1_req_t     l1d_req;
   addr_t       l1i_req_addr;
   line_t       l1_load_data, mem_rsp_load_data;
   mem_req_t    mem_req;
   logic [63:0] l2_cache_accesses, l2_cache_hits;

   integer      seed = seed_value;
   logic [31:0] cycle = '0;
   logic [63:0] exp_accesses = '0;
   logic [63:0] exp_hits = '0;
   exp_t        pending [$];
   exp_t        rsp_exp;
   l1_src_t     ack_log [$];
   addr_t       flushed [$];

   // shadow of memory and of the L2
   line_t              shadow [addr_t];
   logic               ref_valid [l2_lines];
   logic               ref_dirty [l2_lines];
   logic [tag_w-1:0]   ref_tag [l2_lines];
   line_t              ref_line [l2_lines];

   l1_l2_fabric dut (.*);

   tb_mem_model #(.seed_init(seed_value)) mem (
      .clk               (clk),
      .reset             (reset),
      .mem_req_valid     (mem_req_valid),
      .mem_req           (mem_req),
      .mem_rsp_valid     (mem_rsp_valid),
      .mem_rsp_load_data (mem_rsp_load_data)
   );

   always #20 clk = ~clk;

   task automatic check_value(input string name, input logic [line_w-1:0] got,
                              input logic [line_w-1:0] exp);
      if (got !== exp)
      begin
         $display("error %s: got %h expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic line_t shadow_read(input addr_t a);
      return shadow.exists(a) ? shadow[a] : {4{a}};   // word = line address
   endfunction

   function automatic line_t rand_line();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   function automatic l1_req_t make_req(input addr_t a, input mem_op_t kind, input line_t d);
      return '{addr: a, op: kind, data: d};
   endfunction

   // expected result of one request in the order the L2 serves them
   function automatic exp_t ref_access(input l1_src_t src, input l1_req_t req);
      exp_t                   e;
      addr_t                  la;
      logic [lg_l2_lines-1:0] idx;
      logic [tag_w-1:0]       tag;
      la          = {req.addr[addr_w-1:lg_cl_len], {lg_cl_len{1'b0}}};
      idx         = la[lg_cl_len +: lg_l2_lines];
      tag         = la[addr_w-1 -: tag_w];
      e           = '0;
      e.src       = src;
      e.load      = (req.op == mem_ld_line);
      e.hit       = ref_valid[idx] && (ref_tag[idx] == tag);
      e.mem_base  = mem.n_req;
      e.ack_cycle = cycle;
      exp_accesses = exp_accesses + 64'd1;
      if (e.hit)
         exp_hits = exp_hits + 64'd1;
      if (!e.hit && ref_valid[idx] && ref_dirty[idx])
      begin
         shadow[{ref_tag[idx], idx, {lg_cl_len{1'b0}}}] = ref_line[idx];   // victim
         e.mem_ops = e.mem_ops + 8'd1;
      end
      if (!e.load)
      begin
         ref_line[idx]  = req.data;
         ref_dirty[idx] = 1'b1;
      end
      else if (!e.hit)
      begin
         ref_line[idx]  = shadow_read(la);
         ref_dirty[idx] = 1'b0;
         e.mem_ops      = e.mem_ops + 8'd1;
      end
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
      e.data         = ref_line[idx];
      return e;
   endfunction

   function automatic void ref_flush();
      addr_t a;
      flushed.delete();
      for (int i = 0; i < l2_lines; i++)
      begin
         if (ref_valid[i] && ref_dirty[i])
         begin
            a         = {ref_tag[i], lg_l2_lines'(i), {lg_cl_len{1'b0}}};
            shadow[a] = ref_line[i];
            flushed.push_back(a);
         end
         ref_valid[i] = 1'b0;
      end
   endfunction

   task automatic issue_req(input l1_src_t src, input l1_req_t req);
      if (src == src_l1d)
      begin
         l1d_req_valid <= 1'b1;
         l1d_req       <= req;
      end
      else
      begin
         l1i_req_valid <= 1'b1;
         l1i_req_addr  <= req.addr;
      end
      do
         @(posedge clk);
      while (!((src == src_l1d) ? l1d_req_ack : l1i_req_ack));
      if (src == src_l1d)
         l1d_req_valid <= 1'b0;
      else
         l1i_req_valid <= 1'b0;
      ack_log.push_back(src);
      pending.push_back(ref_access(src, req));
   endtask

   task automatic wait_idle();
      while (pending.size() != 0)
         @(posedge clk);
   endtask

   task automatic do_op(input l1_src_t src, input l1_req_t req);
      issue_req(src, req);
      wait_idle();
   endtask

   task automatic run_flush(input logic l1d_first);
      logic [31:0] base;
      base = mem.n_req;
      flush_req_l1i <= 1'b1;
      flush_req_l1d <= 1'b1;
      @(posedge clk);
      flush_req_l1i <= 1'b0;
      flush_req_l1d <= 1'b0;
      @(posedge clk);
      check_value("in_flush_mode", in_flush_mode, 1);
      l1d_flush_complete <= l1d_first;
      l1i_flush_complete <= !l1d_first;
      @(posedge clk);
      l1d_flush_complete <= !l1d_first;
      l1i_flush_complete <= l1d_first;
      @(posedge clk);
      l1d_flush_complete <= 1'b0;
      l1i_flush_complete <= 1'b0;
      while (in_flush_mode)
         @(posedge clk);
      ref_flush();
      foreach (flushed[k])
         check_value("mem line after flush", mem.lines[flushed[k]], shadow[flushed[k]]);
      check_value("flush writebacks", mem.n_req - base, flushed.size());
   endtask

   // response checker
   always @(posedge clk)
   begin
      if (!reset && (l1d_rsp_valid || l1i_rsp_valid))
      begin
         check_value("pending responses", pending.size() != 0, 1);
         rsp_exp = pending.pop_front();
         check_value("rsp port", l1d_rsp_valid ? src_l1d : src_l1i, rsp_exp.src);
         if (rsp_exp.load)
            check_value("l1_load_data", l1_load_data, rsp_exp.data);
         if (rsp_exp.hit)
            check_value("rsp latency", cycle - rsp_exp.ack_cycle, 2);
         check_value("mem requests", mem.n_req - rsp_exp.mem_base, rsp_exp.mem_ops);
         check_value("l2_cache_accesses", l2_cache_accesses, exp_accesses);
         check_value("l2_cache_hits", l2_cache_hits, exp_hits);
      end
   end

   always @(posedge clk)
   begin
      cycle <= cycle + 32'd1;
      if (cycle >= cycle_limit)
      begin
         $display("timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   initial
   begin
      l1_req_t     r;
      logic [31:0] rnd;
      clk                = 1'b0;
      reset              = 1'b1;
      l1d_req_valid      = 1'b0;
      l1d_req            = '0;
      l1i_req_valid      = 1'b0;
      l1i_req_addr       = '0;
      flush_req_l1i      = 1'b0;
      flush_req_l1d      = 1'b0;
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
      foreach (ref_valid[i])
      begin
         ref_valid[i] = 1'b0;
         ref_dirty[i] = 1'b0;
      end
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      do_op(src_l1d, make_req(addr_a, mem_ld_line, '0));   // cold miss
      do_op(src_l1i, make_req(addr_a, mem_ld_line, '0));
      do_op(src_l1d, make_req(addr_a, mem_ld_line, '0));
      do_op(src_l1d, make_req(addr_c, mem_st_line, rand_line()));
      do_op(src_l1i, make_req(addr_c, mem_ld_line, '0));   // stored line without a fill
      do_op(src_l1d, make_req(addr_a, mem_st_line, rand_line()));
      do_op(src_l1d, make_req(addr_b, mem_ld_line, '0));   // evicts dirty a
      check_value("mem line a", mem.lines[addr_a], shadow[addr_a]);
      run_flush(1'b1);
      do_op(src_l1i, make_req(addr_c, mem_ld_line, '0));   // misses after flush
      ack_log.delete();
      fork
         issue_req(src_l1i, make_req(addr_a, mem_ld_line, '0));
         issue_req(src_l1d, make_req(addr_c, mem_ld_line, '0));
      join
      wait_idle();
      check_value("first ack", ack_log[0], src_l1d);
      for (int n = 0; n < 16; n++)
      begin
         rnd = $random(seed);
         r   = make_req({22'h0, rnd[1:0], 2'b00, rnd[3:2], 4'h0},
                        rnd[4] ? mem_st_line : mem_ld_line, rand_line());
         do_op((rnd[4] || !rnd[5]) ? src_l1d : src_l1i, r);
      end
      run_flush(1'b0);
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== build.f ====
design/cache_pkg.sv
design/flush_sequencer.sv
design/l1_req_arbiter.sv
design/l2_arrays.sv
design/l2_ctrl.sv
design/l1_l2_fabric.sv
test/tb_mem_model.sv
test/tb_l1_l2_fabric.sv

// ==== Makefile ====
TOP = tb_l1_l2_fabric

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module l1_l2_fabric

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
